/* verilog/bk_periph_pkg.sv */
////////////////////
// Bus, clock divider, register and audio constants for the BK0011M peripheral front end
////////////////////
`default_nettype none

package bk_periph_pkg;

	typedef logic [15:0] word_t;

	// Bit 1 enables the high byte
	typedef logic [1:0] byte_lane_t;

	////////////////////
	// CPU clock enables
	localparam int CPU_DIV_BK0011  = 23;
	localparam int CPU_DIV_BK0010  = 31;
	localparam int CPU_HALF_BK0011 = 12;
	localparam int CPU_HALF_BK0010 = 16;

	// Write reply delay in bus ticks
	localparam int WRITE_DELAY_BK0011 = 2;

	// Start page reported at 177716, octal 200
	localparam logic [7:0] START_ADDR = 8'o200;

	////////////////////
	// Audio and mouse
	localparam int SPK_SHIFT_MIX    = 5;
	localparam int SPK_SHIFT_SOLO   = 7;
	localparam int AUDIO_PAD        = 6;
	localparam int MOUSE_THRESH_POS = 3;
	localparam int MOUSE_THRESH_NEG = 2;

endpackage

`default_nettype wire

/* verilog/periph_bus_if.sv */
////////////////////
// Decoded write cycle, no handshake; targets sample data on write_pulse
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;

	bk_periph_pkg::word_t      wdata;
	bk_periph_pkg::byte_lane_t lanes;
	logic                      sys_sel;
	logic                      port_sel;

	// One-clock pulses from the cycle sequencer
	logic write_pulse;
	logic access_start;

	modport master (
		output wdata,
		output lanes,
		output sys_sel,
		output port_sel,
		output write_pulse,
		output access_start
	);

	modport target (
		input wdata,
		input lanes,
		input sys_sel,
		input port_sel,
		input write_pulse,
		input access_start
	);

endinterface

`default_nettype wire

/* verilog/ce_timer.sv */
////////////////////
// Turbo changes only at a terminal count outside a bus cycle
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ce_timer #(
	parameter int DIV_11  = bk_periph_pkg::CPU_DIV_BK0011,
	parameter int DIV_10  = bk_periph_pkg::CPU_DIV_BK0010,
	parameter int HALF_11 = bk_periph_pkg::CPU_HALF_BK0011,
	parameter int HALF_10 = bk_periph_pkg::CPU_HALF_BK0010
) (
	input  logic clk_sys,
	input  logic rst,
	input  logic bk0010,
	input  logic turbo_req,
	input  logic bus_sync,
	output logic ce_cpu_p,
	output logic ce_cpu_n,
	output logic ce_bus_2
);

	logic [4:0] cpu_div;
	logic       turbo;
	logic [4:0] term_cnt;
	logic [4:0] half_cnt;

	// Turbo halves both the period and the negative phase position
	assign term_cnt = (bk0010 ? 5'(DIV_10) : 5'(DIV_11)) >> turbo;
	assign half_cnt = (bk0010 ? 5'(HALF_10) : 5'(HALF_11)) >> turbo;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cpu_div  <= '0;
			turbo    <= 1'b0;
			ce_cpu_p <= 1'b0;
			ce_cpu_n <= 1'b0;
			ce_bus_2 <= 1'b0;
		end else begin
			cpu_div <= cpu_div + 5'd1;
			if (cpu_div == term_cnt) begin
				cpu_div <= '0;
				if (!bus_sync)
					turbo <= turbo_req;
			end
			ce_cpu_p <= (cpu_div == 5'd0);
			ce_cpu_n <= (cpu_div == half_cnt);
			// Bus tick trails the CPU phase by one clock
			ce_bus_2 <= ce_cpu_p;
		end
	end

endmodule

`default_nettype wire

/* verilog/bus_cycle_fsm.sv */
////////////////////
// BK0011 write reply waits WRITE_DELAY bus ticks, BK0010 replies at once
////////////////////
`timescale 1ns/1ps
`default_nettype none

module bus_cycle_fsm #(
	parameter int WRITE_DELAY = bk_periph_pkg::WRITE_DELAY_BK0011
) (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic                      ce_bus_2,
	input  logic                      bk0010,
	input  logic                      dout_req,
	input  logic                      din_stb,
	input  logic                      bus_we,
	input  logic                      sys_sel,
	input  logic                      port_sel,
	input  bk_periph_pkg::word_t      wdata,
	input  bk_periph_pkg::byte_lane_t lanes,
	output logic                      dout_ack,
	periph_bus_if.master              bus
);

	localparam int CW = (WRITE_DELAY > 1) ? $clog2(WRITE_DELAY) : 1;

	typedef enum logic [1:0] {
		IDLE,
		DELAY,
		ACTIVE
	} state_t;

	state_t        state;
	logic [CW-1:0] tick_cnt;
	logic          stb;
	logic          stb_q;

	////////////////////
	// Write reply sequencing
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state    <= IDLE;
			tick_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					tick_cnt <= '0;
					if (dout_req)
						state <= bk0010 ? ACTIVE : DELAY;
				end
				DELAY: begin
					if (!dout_req)
						state <= IDLE;
					else if (ce_bus_2) begin
						if (tick_cnt == CW'(WRITE_DELAY - 1))
							state <= ACTIVE;
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				ACTIVE: begin
					// Held until the CPU drops its request
					if (!dout_req)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign dout_ack = (state == ACTIVE);

	////////////////////
	// Strobe edge pulses
	assign stb = dout_ack | din_stb;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			stb_q            <= 1'b0;
			bus.write_pulse  <= 1'b0;
			bus.access_start <= 1'b0;
		end else begin
			stb_q            <= stb;
			bus.write_pulse  <= stb & ~stb_q & bus_we;
			bus.access_start <= stb & ~stb_q & sys_sel;
		end
	end

	assign bus.wdata    = wdata;
	assign bus.lanes    = lanes;
	assign bus.sys_sel  = sys_sel;
	assign bus.port_sel = port_sel;

endmodule

`default_nettype wire

/* verilog/sys_register.sv */
////////////////////
// Register 177716; rdata is zero when not selected
////////////////////
`timescale 1ns/1ps
`default_nettype none

module sys_register (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 bk0010,
	input  logic                 key_down,
	input  logic                 key_stop,
	periph_bus_if.target         bus,
	output bk_periph_pkg::word_t rdata,
	output logic [2:0]           spk,
	output logic                 stop_irq
);

	logic sys_wr;
	logic key_stop_block;
	logic super_flg;

	assign sys_wr = bus.write_pulse & bus.sys_sel;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			spk            <= '0;
			key_stop_block <= 1'b0;
			super_flg      <= 1'b0;
		end else begin
			// write_pulse lines up with access_start, so it marks a write access
			if (bus.access_start)
				super_flg <= bus.write_pulse;
			// Speaker bits load unless bit 11 on the high lane selects the other function
			if (sys_wr && bus.lanes[0] && (!bus.lanes[1] || !bus.wdata[11]))
				spk <= {bus.wdata[6], bus.wdata[5], bus.wdata[2] & ~bk0010};
			if (sys_wr && bus.lanes[1] && !bus.wdata[11])
				key_stop_block <= bus.wdata[12];
		end
	end

	assign rdata = bus.sys_sel ?
		{bk_periph_pkg::START_ADDR, 1'b1, ~key_down, 3'b000, super_flg, 2'b00} : '0;

	assign stop_irq = key_stop & ~key_stop_block;

endmodule

`default_nettype wire

/* verilog/mouse_port.sv */
////////////////////
// Port 177714 read source; mouse mode is ignored while Covox is on
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mouse_port (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 covox_en,
	input  bk_periph_pkg::word_t joystick,
	input  logic [24:0]          ps2_mouse,
	periph_bus_if.target         bus,
	output bk_periph_pkg::word_t rdata
);

	logic [8:0] pointer_dx;
	logic [8:0] pointer_dy;
	logic [6:0] mouse_state;
	logic       mouse_enable;
	logic       mouse_mode;
	logic       toggle_q;
	logic       mouse_wr;

	// Sign bits sit in the packet header byte
	assign pointer_dx = {ps2_mouse[4], ps2_mouse[15:8]};
	assign pointer_dy = {ps2_mouse[5], ps2_mouse[23:16]};

	assign mouse_wr = bus.write_pulse & bus.port_sel & bus.lanes[0] & ~covox_en;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			mouse_state  <= '0;
			mouse_enable <= 1'b0;
			mouse_mode   <= 1'b0;
			toggle_q     <= ps2_mouse[24];
		end else begin
			toggle_q <= ps2_mouse[24];
			if (|joystick)
				mouse_mode <= 1'b0;

			if (mouse_wr) begin
				mouse_enable <= bus.wdata[3];
				if (!bus.wdata[3])
					mouse_state[3:0] <= '0;
			end

			////////////////////
			// New mouse packet
			if (toggle_q != ps2_mouse[24]) begin
				mouse_state[6] <= ps2_mouse[1];
				mouse_state[5] <= ps2_mouse[0];
				mouse_mode     <= 1'b1;
				if (mouse_enable) begin
					// One direction per axis until software clears it
					if (!mouse_state[0] && !mouse_state[2]) begin
						if (!pointer_dy[8] && (pointer_dy > 9'(bk_periph_pkg::MOUSE_THRESH_POS)))
							mouse_state[0] <= 1'b1;
						if (pointer_dy[8] && (~pointer_dy > 9'(bk_periph_pkg::MOUSE_THRESH_NEG)))
							mouse_state[2] <= 1'b1;
					end
					if (!mouse_state[1] && !mouse_state[3]) begin
						if (!pointer_dx[8] && (pointer_dx > 9'(bk_periph_pkg::MOUSE_THRESH_POS)))
							mouse_state[1] <= 1'b1;
						if (pointer_dx[8] && (~pointer_dx > 9'(bk_periph_pkg::MOUSE_THRESH_NEG)))
							mouse_state[3] <= 1'b1;
					end
				end
			end
		end
	end

	always_comb begin
		rdata = '0;
		if (bus.port_sel)
			rdata = (mouse_mode && !covox_en) ? {9'd0, mouse_state} : joystick;
	end

endmodule

`default_nettype wire

/* verilog/covox_audio.sv */
////////////////////
// Unsigned output; low port byte drives left, high byte drives right
////////////////////
`timescale 1ns/1ps
`default_nettype none

module covox_audio (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 covox_en,
	input  logic [2:0]           spk,
	periph_bus_if.target         bus,
	output bk_periph_pkg::word_t audio_l,
	output bk_periph_pkg::word_t audio_r
);

	logic [15:0] covox_byte;

	always_ff @(posedge clk_sys) begin
		if (rst)
			covox_byte <= '0;
		else if (bus.write_pulse && bus.port_sel) begin
			if (bus.lanes[0])
				covox_byte[7:0] <= bus.wdata[7:0];
			if (bus.lanes[1])
				covox_byte[15:8] <= bus.wdata[15:8];
		end
	end

	// 10-bit channel mix with the speaker alone when Covox is off
	function automatic logic [9:0] mix(input logic [7:0] sample, input logic [2:0] spk_bits,
			input logic cov_on);
		logic [9:0] spk_mix;
		logic [9:0] spk_solo;
		spk_mix  = 10'(spk_bits) << bk_periph_pkg::SPK_SHIFT_MIX;
		spk_solo = 10'(spk_bits) << bk_periph_pkg::SPK_SHIFT_SOLO;
		return cov_on ? ({1'b0, sample, 1'b0} + spk_mix) : spk_solo;
	endfunction

	assign audio_l = {mix(covox_byte[7:0], spk, covox_en), {bk_periph_pkg::AUDIO_PAD{1'b0}}};
	assign audio_r = {mix(covox_byte[15:8], spk, covox_en), {bk_periph_pkg::AUDIO_PAD{1'b0}}};

endmodule

`default_nettype wire

/* verilog/bk_periph_top.sv */
////////////////////
// Selects come decoded from the CPU; replies for them are generated inside the CPU
////////////////////
`timescale 1ns/1ps
`default_nettype none

module bk_periph_top (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic                      bk0010,
	input  logic                      turbo_req,
	input  logic                      covox_en,
	input  logic                      bus_sync,
	input  logic                      dout_req,
	input  logic                      din_stb,
	input  logic                      bus_we,
	input  logic                      sys_sel,
	input  logic                      port_sel,
	input  bk_periph_pkg::word_t      bus_wdata,
	input  bk_periph_pkg::byte_lane_t bus_wtbt,
	input  logic                      key_down,
	input  logic                      key_stop,
	input  bk_periph_pkg::word_t      joystick,
	input  logic [24:0]               ps2_mouse,
	output logic                      ce_cpu_p,
	output logic                      ce_cpu_n,
	output logic                      dout_ack,
	output logic                      stop_irq,
	output bk_periph_pkg::word_t      bus_rdata,
	output bk_periph_pkg::word_t      audio_l,
	output bk_periph_pkg::word_t      audio_r
);

	logic                 ce_bus_2;
	logic [2:0]           spk;
	bk_periph_pkg::word_t sys_rdata;
	bk_periph_pkg::word_t port_rdata;

	periph_bus_if bus ();

	ce_timer #(
		.DIV_11  (bk_periph_pkg::CPU_DIV_BK0011),
		.DIV_10  (bk_periph_pkg::CPU_DIV_BK0010),
		.HALF_11 (bk_periph_pkg::CPU_HALF_BK0011),
		.HALF_10 (bk_periph_pkg::CPU_HALF_BK0010)
	) u_ce_timer (
		.clk_sys,
		.rst,
		.bk0010,
		.turbo_req,
		.bus_sync,
		.ce_cpu_p,
		.ce_cpu_n,
		.ce_bus_2
	);

	bus_cycle_fsm #(
		.WRITE_DELAY (bk_periph_pkg::WRITE_DELAY_BK0011)
	) u_bus_cycle_fsm (
		.clk_sys,
		.rst,
		.ce_bus_2,
		.bk0010,
		.dout_req,
		.din_stb,
		.bus_we,
		.sys_sel,
		.port_sel,
		.wdata    (bus_wdata),
		.lanes    (bus_wtbt),
		.dout_ack,
		.bus      (bus.master)
	);

	sys_register u_sys_register (
		.clk_sys,
		.rst,
		.bk0010,
		.key_down,
		.key_stop,
		.bus      (bus.target),
		.rdata    (sys_rdata),
		.spk,
		.stop_irq
	);

	mouse_port u_mouse_port (
		.clk_sys,
		.rst,
		.covox_en,
		.joystick,
		.ps2_mouse,
		.bus       (bus.target),
		.rdata     (port_rdata)
	);

	covox_audio u_covox_audio (
		.clk_sys,
		.rst,
		.covox_en,
		.spk,
		.bus      (bus.target),
		.audio_l,
		.audio_r
	);

	// Unselected sources return zero, so a plain OR merges them
	always_ff @(posedge clk_sys)
		bus_rdata <= sys_rdata | port_rdata;

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
////////////////////
// 20 ns clock, reset held high for the first 5 rising edges
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_sys,
	output logic rst
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#2 rst = 1'b0;
	end

endmodule

`default_nettype wire

/* testbench/tb_bk_periph.sv */
////////////////////
// Inputs change 2 ns after the rising edge; outputs are sampled at that point
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_bk_periph;

	// Limit is a few times the length of all six tests
	localparam int MAX_CYCLES = 4000;
	localparam int ACK_WAIT   = 100;

	logic        clk_sys;
	logic        rst;
	logic        bk0010;
	logic        turbo_req;
	logic        covox_en;
	logic        bus_sync;
	logic        dout_req;
	logic        din_stb;
	logic        bus_we;
	logic        sys_sel;
	logic        port_sel;
	logic [15:0] bus_wdata;
	logic [1:0]  bus_wtbt;
	logic        key_down;
	logic        key_stop;
	logic [15:0] joystick;
	logic [24:0] ps2_mouse;
	logic        ce_cpu_p;
	logic        ce_cpu_n;
	logic        dout_ack;
	logic        stop_irq;
	logic [15:0] bus_rdata;
	logic [15:0] audio_l;
	logic [15:0] audio_r;

	logic [31:0] lfsr_state;
	logic        ack_prev;
	int          errors;
	int          checks;
	int          tests_run;
	int          test_errors_start;
	int          cycle_count;

	tb_clock clock0 (
		.clk_sys (clk_sys),
		.rst     (rst)
	);

	bk_periph_top dut0 (
		.clk_sys, .rst, .bk0010, .turbo_req, .covox_en, .bus_sync,
		.dout_req, .din_stb, .bus_we, .sys_sel, .port_sel, .bus_wdata, .bus_wtbt,
		.key_down, .key_stop, .joystick, .ps2_mouse,
		.ce_cpu_p, .ce_cpu_n, .dout_ack, .stop_irq, .bus_rdata, .audio_l, .audio_r
	);

	////////////////////
	// Helpers

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Reference mix as a 10-bit level with 6 zero bits below it
	function automatic logic [15:0] audio_expect(input logic [2:0] spk, input logic covox,
			input logic [7:0] sample);
		logic [9:0] level;
		if (covox)
			level = 10'(sample) * 10'd2 + 10'(spk) * 10'd32;
		else
			level = 10'(spk) * 10'd128;
		return 16'(level) * 16'd64;
	endfunction

	task automatic take_random(input int width, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < width; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[14:0], lfsr_state[0]};
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		checks++;
		assert (actual === expected) else begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (dout_ack !== level && n < ACK_WAIT) begin
			next_cycle();
			n++;
		end
		if (dout_ack !== level) begin
			$display("dout_ack did not go to %0b within %0d cycles at %0t ns",
				level, ACK_WAIT, $time);
			errors++;
		end
	endtask

	task automatic bus_write(input logic to_sys, input logic [15:0] data,
			input logic [1:0] lanes);
		next_cycle();
		sys_sel   = to_sys;
		port_sel  = !to_sys;
		bus_wdata = data;
		bus_wtbt  = lanes;
		bus_we    = 1'b1;
		dout_req  = 1'b1;
		wait_ack(1'b1);
		next_cycle();
		dout_req = 1'b0;
		wait_ack(1'b0);
		next_cycle();
		sys_sel  = 1'b0;
		port_sel = 1'b0;
		bus_we   = 1'b0;
	endtask

	// Select held for two clocks, data taken after the first
	task automatic bus_read(input logic to_sys, output logic [15:0] data);
		next_cycle();
		sys_sel  = to_sys;
		port_sel = !to_sys;
		bus_we   = 1'b0;
		din_stb  = 1'b1;
		next_cycle();
		data = bus_rdata;
		next_cycle();
		din_stb  = 1'b0;
		sys_sel  = 1'b0;
		port_sel = 1'b0;
	endtask

	task automatic wait_ce_pulse(output int clocks);
		clocks = 1;
		next_cycle();
		while (!ce_cpu_p && clocks < ACK_WAIT) begin
			next_cycle();
			clocks++;
		end
	endtask

	// Clocks from a ce_cpu_p pulse to the following ce_cpu_n pulse
	task automatic clocks_to_ce_n(output int clocks);
		clocks = 1;
		next_cycle();
		while (!ce_cpu_n && clocks < ACK_WAIT) begin
			next_cycle();
			clocks++;
		end
	endtask

	task automatic open_test();
		test_errors_start = errors;
	endtask

	task automatic report_test(input int num, input string name);
		tests_run++;
		if (errors == test_errors_start)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, errors - test_errors_start);
	endtask

	////////////////////
	// Monitors

	// The reply must never rise without a pending request
	always @(negedge clk_sys) begin
		if (!rst && dout_ack && !ack_prev) begin
			checks++;
			assert (dout_req) else begin
				$display("dout_ack rose without dout_req at %0t ns", $time);
				errors++;
			end
		end
		ack_prev = dout_ack;
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////
	// Stimulus
	initial begin
		int          period;
		int          offset;
		logic [15:0] data;
		logic [15:0] rnd;
		logic [15:0] rd;
		logic [1:0]  lanes;
		logic [2:0]  spk_model;
		logic        block_model;
		logic [7:0]  cov_lo;
		logic [7:0]  cov_hi;

		bk0010 = 1'b0;
		turbo_req = 1'b0;
		covox_en = 1'b0;
		bus_sync = 1'b0;
		dout_req = 1'b0;
		din_stb = 1'b0;
		bus_we = 1'b0;
		sys_sel = 1'b0;
		port_sel = 1'b0;
		bus_wdata = '0;
		bus_wtbt = '0;
		key_down = 1'b0;
		key_stop = 1'b0;
		joystick = '0;
		ps2_mouse = '0;
		lfsr_state = 32'hfe05;
		ack_prev = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		cycle_count = 0;
		spk_model = '0;
		block_model = 1'b0;
		cov_lo = '0;
		cov_hi = '0;

		wait (rst == 1'b0);
		next_cycle();

		// Test 1 discards two pulses so a turbo change can settle
		open_test();
		for (int i = 0; i < 4; i++) begin
			bk0010    = i[0];
			turbo_req = i[1];
			wait_ce_pulse(period);
			wait_ce_pulse(period);
			wait_ce_pulse(period);
			check_value("ce_cpu_p period", 16'(period),
				i[1] ? (i[0] ? 16'd16 : 16'd12) : (i[0] ? 16'd32 : 16'd24));
			// Negative phase sits half a period after the positive one
			clocks_to_ce_n(offset);
			check_value("ce_cpu_n offset", 16'(offset),
				i[1] ? (i[0] ? 16'd8 : 16'd6) : (i[0] ? 16'd16 : 16'd12));
		end
		report_test(1, "ce_cpu_p spacing");

		// Test 2 runs BK0011 first, then BK0010 with bit 2 masked
		open_test();
		for (int n = 0; n < 8; n++) begin
			bk0010 = (n >= 4);
			take_random(16, data);
			take_random(2, rnd);
			lanes = rnd[1:0];
			// Last write of each model always loads the speaker with bit 2 set
			if (n == 3 || n == 7) begin
				data[2] = 1'b1;
				lanes   = 2'b01;
			end
			bus_write(1'b1, data, lanes);
			if (lanes[0] && (!lanes[1] || !data[11]))
				spk_model = {data[6], data[5], data[2] && !bk0010};
			if (lanes[1] && !data[11])
				block_model = data[12];
			check_value("audio_l", audio_l, audio_expect(spk_model, 1'b0, 8'h00));
			check_value("audio_r", audio_r, audio_expect(spk_model, 1'b0, 8'h00));
		end
		report_test(2, "speaker write with Covox off");

		// 3
		open_test();
		covox_en = 1'b1;
		for (int n = 0; n < 6; n++) begin
			take_random(16, data);
			take_random(2, rnd);
			lanes = rnd[1:0];
			bus_write(1'b0, data, lanes);
			if (lanes[0])
				cov_lo = data[7:0];
			if (lanes[1])
				cov_hi = data[15:8];
			check_value("audio_l", audio_l, audio_expect(spk_model, 1'b1, cov_lo));
			check_value("audio_r", audio_r, audio_expect(spk_model, 1'b1, cov_hi));
		end
		covox_en = 1'b0;
		report_test(3, "Covox mix");

		// Test 4 makes a write access, then two reads
		open_test();
		key_down = 1'b0;
		bus_write(1'b1, 16'h0000, 2'b00);
		bus_read(1'b1, rd);
		check_value("bus_rdata", rd,
			(16'(bk_periph_pkg::START_ADDR) << 8) | 16'h0080 | 16'h0040 | 16'h0004);
		key_down = 1'b1;
		bus_read(1'b1, rd);
		check_value("bus_rdata", rd, (16'(bk_periph_pkg::START_ADDR) << 8) | 16'h0080);
		key_down = 1'b0;
		report_test(4, "system register read");

		// Test 5 presses both buttons and moves dy 5 upward
		open_test();
		bus_write(1'b0, 16'h0008, 2'b01);
		ps2_mouse = {1'b1, 8'd5, 8'd0, 8'h0b};
		next_cycle();
		bus_read(1'b0, rd);
		check_value("bus_rdata", rd, 16'h0061);
		take_random(16, data);
		joystick = data | 16'h0001;
		bus_read(1'b0, rd);
		check_value("bus_rdata", rd, joystick);
		report_test(5, "mouse and joystick port");

		// 6
		open_test();
		key_stop = 1'b1;
		next_cycle();
		check_value("stop_irq", 16'(stop_irq), 16'(!block_model));
		bus_write(1'b1, 16'h1000, 2'b10);
		check_value("stop_irq", 16'(stop_irq), 16'h0000);
		bus_write(1'b1, 16'h0000, 2'b10);
		check_value("stop_irq", 16'(stop_irq), 16'h0001);
		key_stop = 1'b0;
		report_test(6, "stop key block");

		$display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* bk_periph.f */
verilog/bk_periph_pkg.sv
verilog/periph_bus_if.sv
verilog/ce_timer.sv
verilog/bus_cycle_fsm.sv
verilog/sys_register.sv
verilog/mouse_port.sv
verilog/covox_audio.sv
verilog/bk_periph_top.sv
testbench/tb_clock.sv
testbench/tb_bk_periph.sv

/* Bender.yml */
package:
  name: bk_periph

sources:
  - verilog/bk_periph_pkg.sv
  - verilog/periph_bus_if.sv
  - verilog/ce_timer.sv
  - verilog/bus_cycle_fsm.sv
  - verilog/sys_register.sv
  - verilog/mouse_port.sv
  - verilog/covox_audio.sv
  - verilog/bk_periph_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_bk_periph.sv
